//--- verilog/mem_test_pkg.sv
`default_nettype none

package mem_test_pkg;

    localparam int NUM_WORDS = 64;
    localparam int IDX_W = $clog2(NUM_WORDS);
    localparam int ADDR_W = 28;
    localparam int DATA_W = 128;
    localparam int MASK_W = 16;
    localparam logic [DATA_W-1:0] DATA_BASE = 128'hc0ffee15_5eed1e55_0ddba11a_7ab1e5ec;
    localparam int ADDR_STEP = 8;

    localparam int UART_CLKS_PER_BIT = 16;
    localparam int BIT_TIMER_W = $clog2(UART_CLKS_PER_BIT);

    // fixed read latency of the memory model
    localparam int READ_LATENCY = 4;

    typedef enum logic [2:0] {
        MEM_WRITE = 3'd0,
        MEM_READ  = 3'd1
    } mem_op_e;

    typedef enum logic [1:0] {
        GEN_IDLE, GEN_WRITE, GEN_READ, GEN_PARK
    } gen_state_e;

    typedef enum logic [2:0] {
        REP_WAIT_WRITE, REP_SEND_WRITE, REP_WAIT_CHECK,
        REP_SEND_READ, REP_SEND_INDEX, REP_DONE
    } rep_state_e;

    typedef enum logic [1:0] {
        UART_IDLE, UART_START, UART_DATA, UART_STOP
    } uart_state_e;

    typedef struct packed {
        mem_op_e             op;
        logic [ADDR_W-1:0]   addr;
    } mem_cmd_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [MASK_W-1:0]   mask;
    } mem_wdata_t;

    typedef struct packed {
        logic                valid;
        logic [DATA_W-1:0]   data;
    } mem_rdata_t;

    typedef struct packed {
        logic                pass;
        logic [31:0]         bad_index;
    } check_result_t;

endpackage

`default_nettype wire

//--- verilog/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx import mem_test_pkg::*; (
    input  wire logic       clk_100,
    input  wire logic       reset_n,
    input  wire logic [7:0] data,
    input  wire logic       en,
    output logic            rdy,
    output logic            tx
);

    uart_state_e state;
    logic [BIT_TIMER_W-1:0] timer;
    logic [2:0] bit_idx;
    logic [7:0] shift_reg;
    logic bit_end;

    assign bit_end = timer == BIT_TIMER_W'(UART_CLKS_PER_BIT - 1);

    // the byte counts as taken only once the whole frame is on the line
    assign rdy = (state == UART_STOP) && bit_end;

    always_ff @(posedge clk_100) begin
        if (!reset_n) begin
            state <= UART_IDLE;
            tx <= 1'b1;
            timer <= '0;
            bit_idx <= '0;
        end else begin
            timer <= (state == UART_IDLE || bit_end) ? '0 : timer + 1'b1;
            case (state)
                UART_IDLE: begin
                    if (en) begin
                        tx <= 1'b0;
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_end) begin
                        tx <= shift_reg[0];
                        bit_idx <= '0;
                        state <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            tx <= 1'b1;
                            state <= UART_STOP;
                        end else begin
                            tx <= shift_reg[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                UART_STOP: begin
                    if (bit_end) state <= UART_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_100) begin
        if (state == UART_IDLE && en) begin
            shift_reg <= data;
        end else if (bit_end && (state == UART_START || state == UART_DATA)) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    // the sender must keep the byte on offer until the frame is finished
    assert property (@(posedge clk_100) disable iff (!reset_n)
        en && !rdy |=> en && $stable(data));

endmodule

`default_nettype wire

//--- verilog/traffic_gen.sv
`timescale 1ns/100ps
`default_nettype none

module traffic_gen import mem_test_pkg::*; (
    input  wire logic       clk_100,
    input  wire logic       reset_n,
    input  wire logic       calib_done,
    output mem_cmd_t        cmd,
    output logic            cmd_en,
    input  wire logic       cmd_rdy,
    output mem_wdata_t      wdata,
    output logic            wdata_en,
    input  wire logic       wdata_rdy,
    output logic            write_done,
    output logic [63:0]     write_cycles,
    output logic            read_start
);

    gen_state_e state;
    logic [IDX_W-1:0] word_idx;
    logic last_word;
    logic word_done;

    assign last_word = word_idx == IDX_W'(NUM_WORDS - 1);

    // a port is finished with the word when it transfers now or already has
    assign word_done = (!cmd_en || cmd_rdy) && (!wdata_en || wdata_rdy);

    assign cmd.op = (state == GEN_READ) ? MEM_READ : MEM_WRITE;
    assign cmd.addr = ADDR_W'(word_idx * ADDR_STEP);
    assign wdata.data = DATA_BASE + DATA_W'(word_idx);
    assign wdata.mask = '0;

    always_ff @(posedge clk_100) begin
        if (!reset_n) begin
            state <= GEN_IDLE;
            word_idx <= '0;
            cmd_en <= 1'b0;
            wdata_en <= 1'b0;
            write_done <= 1'b0;
            write_cycles <= '0;
            read_start <= 1'b0;
        end else begin
            write_done <= 1'b0;
            read_start <= 1'b0;
            case (state)
                GEN_IDLE: begin
                    if (calib_done) begin
                        cmd_en <= 1'b1;
                        wdata_en <= 1'b1;
                        state <= GEN_WRITE;
                    end
                end
                GEN_WRITE: begin
                    write_cycles <= write_cycles + 64'd1;
                    if (word_done) begin
                        if (last_word) begin
                            // reads start right away, the first one is already on cmd
                            word_idx <= '0;
                            cmd_en <= 1'b1;
                            wdata_en <= 1'b0;
                            write_done <= 1'b1;
                            read_start <= 1'b1;
                            state <= GEN_READ;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                            cmd_en <= 1'b1;
                            wdata_en <= 1'b1;
                        end
                    end else begin
                        if (cmd_en && cmd_rdy) cmd_en <= 1'b0;
                        if (wdata_en && wdata_rdy) wdata_en <= 1'b0;
                    end
                end
                GEN_READ: begin
                    if (cmd_rdy) begin
                        if (last_word) begin
                            cmd_en <= 1'b0;
                            state <= GEN_PARK;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                        end
                    end
                end
                GEN_PARK: begin
                    cmd_en <= 1'b0;
                end
            endcase
        end
    end

    assert property (@(posedge clk_100) disable iff (!reset_n)
        cmd_en && !cmd_rdy |=> cmd_en && $stable(cmd));

    assert property (@(posedge clk_100) disable iff (!reset_n)
        wdata_en && !wdata_rdy |=> wdata_en && $stable(wdata));

endmodule

`default_nettype wire

//--- verilog/read_checker.sv
`timescale 1ns/100ps
`default_nettype none

module read_checker import mem_test_pkg::*; (
    input  wire logic       clk_100,
    input  wire logic       reset_n,
    input  wire mem_rdata_t rdata,
    output logic            check_done,
    output check_result_t   result
);

    logic [IDX_W-1:0] exp_idx;
    logic [DATA_W-1:0] expected;
    logic last_word;
    logic all_seen;
    logic reported;
    logic mismatch;

    assign expected = DATA_BASE + DATA_W'(exp_idx);
    assign last_word = exp_idx == IDX_W'(NUM_WORDS - 1);
    assign mismatch = rdata.data != expected;

    always_ff @(posedge clk_100) begin
        if (!reset_n) begin
            exp_idx <= '0;
            all_seen <= 1'b0;
            reported <= 1'b0;
            check_done <= 1'b0;
        end else begin
            check_done <= 1'b0;
            // words after a failure are still counted but no longer compared
            if (rdata.valid && !all_seen) begin
                exp_idx <= exp_idx + 1'b1;
                if (last_word) all_seen <= 1'b1;
                if (!reported && (mismatch || last_word)) begin
                    reported <= 1'b1;
                    check_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_100) begin
        if (rdata.valid && !all_seen && !reported) begin
            result.pass <= !mismatch;
            result.bad_index <= mismatch ? 32'(exp_idx) : '0;
        end
    end

    // the memory returns exactly one word per read command
    assert property (@(posedge clk_100) disable iff (!reset_n)
        rdata.valid |-> !all_seen);

endmodule

`default_nettype wire

//--- verilog/result_reporter.sv
`timescale 1ns/100ps
`default_nettype none

module result_reporter import mem_test_pkg::*; (
    input  wire logic          clk_100,
    input  wire logic          reset_n,
    input  wire logic          write_done,
    input  wire logic [63:0]   write_cycles,
    input  wire logic          read_start,
    input  wire logic          check_done,
    input  wire check_result_t result,
    output logic [7:0]         uart_data,
    output logic               uart_en,
    input  wire logic          uart_rdy,
    output logic               success_led,
    output logic               error_led
);

    rep_state_e state;
    logic [63:0] read_cycles;
    logic reading;
    logic check_seen;
    check_result_t held_result;
    logic [63:0] shift_word;
    logic [2:0] byte_idx;
    logic [63:0] second_word;

    assign uart_data = shift_word[7:0];
    assign second_word = held_result.pass ? read_cycles : 64'(held_result.bad_index);

    always_ff @(posedge clk_100) begin
        if (!reset_n) begin
            state <= REP_WAIT_WRITE;
            read_cycles <= '0;
            reading <= 1'b0;
            check_seen <= 1'b0;
            byte_idx <= '0;
            uart_en <= 1'b0;
            success_led <= 1'b0;
            error_led <= 1'b0;
        end else begin
            if ((read_start || reading) && !check_done) read_cycles <= read_cycles + 64'd1;
            if (read_start) reading <= 1'b1;
            if (check_done) begin
                reading <= 1'b0;
                check_seen <= 1'b1;
            end

            case (state)
                REP_WAIT_WRITE: begin
                    if (write_done) begin
                        shift_word <= write_cycles;
                        byte_idx <= '0;
                        uart_en <= 1'b1;
                        state <= REP_SEND_WRITE;
                    end
                end
                REP_SEND_WRITE: begin
                    if (uart_rdy) begin
                        if (byte_idx != 3'd7) begin
                            shift_word <= {8'h0, shift_word[63:8]};
                            byte_idx <= byte_idx + 1'b1;
                        end else if (check_seen) begin
                            // a result that came in meanwhile goes out straight after
                            shift_word <= second_word;
                            byte_idx <= '0;
                            state <= held_result.pass ? REP_SEND_READ : REP_SEND_INDEX;
                        end else begin
                            uart_en <= 1'b0;
                            state <= REP_WAIT_CHECK;
                        end
                    end
                end
                REP_WAIT_CHECK: begin
                    if (check_seen) begin
                        shift_word <= second_word;
                        byte_idx <= '0;
                        uart_en <= 1'b1;
                        state <= held_result.pass ? REP_SEND_READ : REP_SEND_INDEX;
                    end
                end
                REP_SEND_READ, REP_SEND_INDEX: begin
                    if (uart_rdy) begin
                        if (byte_idx != 3'd7) begin
                            shift_word <= {8'h0, shift_word[63:8]};
                            byte_idx <= byte_idx + 1'b1;
                        end else begin
                            uart_en <= 1'b0;
                            success_led <= state == REP_SEND_READ;
                            error_led <= state == REP_SEND_INDEX;
                            state <= REP_DONE;
                        end
                    end
                end
                REP_DONE: begin
                    uart_en <= 1'b0;
                end
                default: state <= REP_DONE;
            endcase
        end
    end

    always_ff @(posedge clk_100) begin
        if (check_done) held_result <= result;
    end

endmodule

`default_nettype wire

//--- verilog/mem_test_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_test_top import mem_test_pkg::*; (
    input  wire logic       clk_100,
    input  wire logic       reset_n,
    input  wire logic       calib_done,
    output mem_cmd_t        cmd,
    output logic            cmd_en,
    input  wire logic       cmd_rdy,
    output mem_wdata_t      wdata,
    output logic            wdata_en,
    input  wire logic       wdata_rdy,
    input  wire mem_rdata_t rdata,
    output logic            tx,
    output logic            success_led,
    output logic            error_led
);

    logic write_done;
    logic [63:0] write_cycles;
    logic read_start;
    logic check_done;
    check_result_t result;
    logic [7:0] uart_data;
    logic uart_en;
    logic uart_rdy;

    traffic_gen traffic_gen_i (
        .clk_100      (clk_100),
        .reset_n      (reset_n),
        .calib_done   (calib_done),
        .cmd          (cmd),
        .cmd_en       (cmd_en),
        .cmd_rdy      (cmd_rdy),
        .wdata        (wdata),
        .wdata_en     (wdata_en),
        .wdata_rdy    (wdata_rdy),
        .write_done   (write_done),
        .write_cycles (write_cycles),
        .read_start   (read_start)
    );

    read_checker read_checker_i (
        .clk_100    (clk_100),
        .reset_n    (reset_n),
        .rdata      (rdata),
        .check_done (check_done),
        .result     (result)
    );

    result_reporter result_reporter_i (
        .clk_100      (clk_100),
        .reset_n      (reset_n),
        .write_done   (write_done),
        .write_cycles (write_cycles),
        .read_start   (read_start),
        .check_done   (check_done),
        .result       (result),
        .uart_data    (uart_data),
        .uart_en      (uart_en),
        .uart_rdy     (uart_rdy),
        .success_led  (success_led),
        .error_led    (error_led)
    );

    uart_tx uart_tx_i (
        .clk_100 (clk_100),
        .reset_n (reset_n),
        .data    (uart_data),
        .en      (uart_en),
        .rdy     (uart_rdy),
        .tx      (tx)
    );

endmodule

`default_nettype wire

//--- bench/mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module mem_model import mem_test_pkg::*; (
    input  wire logic       clk_100,
    input  wire logic       reset_n,
    input  wire mem_cmd_t   cmd,
    input  wire logic       cmd_en,
    output logic            cmd_rdy,
    input  wire mem_wdata_t wdata,
    input  wire logic       wdata_en,
    output logic            wdata_rdy,
    output mem_rdata_t      rdata,
    input  wire logic [7:0] cmd_stall,
    input  wire logic [7:0] wdata_stall,
    input  wire logic       fault_en,
    input  wire logic [7:0] fault_idx
);

    logic [DATA_W-1:0] mem [NUM_WORDS];
    int wr_count [NUM_WORDS];
    int bad_addr_count;
    logic [ADDR_W-1:0] addr_q [$];
    logic [DATA_W-1:0] data_q [$];
    mem_rdata_t pipe [READ_LATENCY];
    int idx;
    integer seed = 32'hef30ebfd;

    initial begin
        cmd_rdy = 1'b0;
        wdata_rdy = 1'b0;
        rdata = '0;
    end

    // transfers are taken on the rising edge and answers go back on the falling edge
    always @(posedge clk_100) begin
        if (!reset_n) begin
            addr_q.delete();
            data_q.delete();
            bad_addr_count = 0;
            for (int i = 0; i < NUM_WORDS; i++) begin
                mem[i] = '0;
                wr_count[i] = 0;
            end
            for (int i = 0; i < READ_LATENCY; i++) begin
                pipe[i] = '0;
            end
        end else begin
            if (cmd_en && cmd_rdy && cmd.op == MEM_WRITE) addr_q.push_back(cmd.addr);
            if (wdata_en && wdata_rdy) data_q.push_back(wdata.data);
            // a word is stored once both of its halves have arrived
            if (addr_q.size() > 0 && data_q.size() > 0) begin
                idx = int'(addr_q[0]) / ADDR_STEP;
                if (int'(addr_q[0]) % ADDR_STEP != 0 || idx >= NUM_WORDS) begin
                    bad_addr_count++;
                end else begin
                    mem[idx] = data_q[0];
                    wr_count[idx]++;
                end
                void'(addr_q.pop_front());
                void'(data_q.pop_front());
            end
            for (int i = READ_LATENCY - 1; i > 0; i--) begin
                pipe[i] = pipe[i-1];
            end
            pipe[0] = '0;
            if (cmd_en && cmd_rdy && cmd.op == MEM_READ) begin
                idx = int'(cmd.addr) / ADDR_STEP;
                pipe[0].valid = 1'b1;
                pipe[0].data = mem[idx];
                // the fault only shows on the returned copy
                if (fault_en && idx == int'(fault_idx)) pipe[0].data[0] = ~pipe[0].data[0];
            end
        end
    end

    always @(negedge clk_100) begin
        cmd_rdy = ($unsigned($random(seed)) % 100) >= cmd_stall;
        wdata_rdy = ($unsigned($random(seed)) % 100) >= wdata_stall;
        rdata = pipe[READ_LATENCY-1];
    end

endmodule

`default_nettype wire

//--- bench/tb_mem_test.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_test import mem_test_pkg::*; ();

    typedef struct packed {
        logic [7:0] calib_delay;
        logic [7:0] cmd_stall;
        logic [7:0] wdata_stall;
        logic       fault_en;
        logic [7:0] fault_idx;
    } row_t;

    localparam int NUM_ROWS = 5;
    localparam int CYCLE_LIMIT =
        NUM_ROWS * (NUM_WORDS * 8 + 16 * 10 * UART_CLKS_PER_BIT + 1000);

    logic clk_100;
    logic reset_n;
    logic calib_done;
    mem_cmd_t cmd;
    logic cmd_en;
    logic cmd_rdy;
    mem_wdata_t wdata;
    logic wdata_en;
    logic wdata_rdy;
    mem_rdata_t rdata;
    logic tx;
    logic success_led;
    logic error_led;
    logic [7:0] cmd_stall;
    logic [7:0] wdata_stall;
    logic fault_en;
    logic [7:0] fault_idx;

    row_t rows [NUM_ROWS];
    logic [7:0] rx_bytes [$];
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    // measured at the memory ports and cleared by every reset
    int exp_write_cycles;
    int exp_read_cycles;
    int cmd_xfers;
    int wdata_xfers;
    int read_words;
    logic reads_seen;
    int ready_cycle;
    int first_cmd_cycle;
    logic early_cmd;
    int masked_writes;

    mem_test_top dut_i (.*);

    mem_model model_i (.*);

    initial begin
        clk_100 = 1'b0;
        forever #5 clk_100 = ~clk_100;
    end

    always @(posedge clk_100) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end else if (!reset_n) begin
            exp_write_cycles = 0;
            exp_read_cycles = 0;
            cmd_xfers = 0;
            wdata_xfers = 0;
            read_words = 0;
            reads_seen = 1'b0;
            ready_cycle = -1;
            first_cmd_cycle = -1;
            early_cmd = 1'b0;
            masked_writes = 0;
        end else begin
            if (calib_done && ready_cycle < 0) ready_cycle = cycle_count;
            if (cmd_en && first_cmd_cycle < 0) first_cmd_cycle = cycle_count;
            if (cmd_en && !calib_done) early_cmd = 1'b1;
            if (wdata_en && wdata.mask !== '0) masked_writes++;
            // the write phase lasts until both ports have moved every word
            if ((cmd_xfers < NUM_WORDS || wdata_xfers < NUM_WORDS)
                    && (wdata_en || (cmd_en && cmd.op == MEM_WRITE))) begin
                exp_write_cycles++;
                if (cmd_en && cmd_rdy && cmd.op == MEM_WRITE) cmd_xfers++;
                if (wdata_en && wdata_rdy) wdata_xfers++;
            end
            if (cmd_en && cmd.op == MEM_READ) reads_seen = 1'b1;
            if (reads_seen && read_words < NUM_WORDS) begin
                exp_read_cycles++;
                if (rdata.valid) read_words++;
            end
        end
    end

    task automatic compare_value(input string name, input logic [127:0] got,
            input logic [127:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("ERROR %s: got %0h, expected %0h", name, got, expected);
            error_count++;
        end
    endtask

    // called on the edge where the start bit was first seen
    task automatic receive_frame();
        logic [7:0] value;
        logic level;
        logic good;
        good = 1'b1;
        value = '0;
        level = 1'b0;
        for (int b = 0; b < 10; b++) begin
            for (int c = 0; c < UART_CLKS_PER_BIT; c++) begin
                if (b != 0 || c != 0) @(posedge clk_100);
                if (c == 0) level = tx;
                else if (tx !== level) good = 1'b0;
            end
            if (b == 0 && level !== 1'b0) good = 1'b0;
            if (b == 9 && level !== 1'b1) good = 1'b0;
            if (b >= 1 && b <= 8) value[b-1] = level;
        end
        if (!good) begin
            $display("uart frame %0d is malformed", rx_bytes.size());
            error_count++;
        end
        rx_bytes.push_back(value);
    endtask

    initial begin
        forever begin
            @(posedge clk_100);
            if (reset_n && tx === 1'b0) receive_frame();
        end
    end

    task automatic load_table();
        // calib delay, cmd stall in percent, wdata stall in percent, fault on, fault index
        rows[0] = '{8'd0, 8'd0, 8'd0, 1'b0, 8'd0};
        rows[1] = '{8'd20, 8'd30, 8'd30, 1'b0, 8'd0};
        rows[2] = '{8'd3, 8'd50, 8'd10, 1'b1, 8'd17};
        rows[3] = '{8'd40, 8'd10, 8'd50, 1'b1, 8'd63};
        rows[4] = '{8'd7, 8'd25, 8'd25, 1'b0, 8'd0};
    endtask

    task automatic run_row(input int r);
        logic [63:0] first_word;
        logic [63:0] second_word;
        int errors_before;
        errors_before = error_count;
        first_word = '0;
        second_word = '0;
        @(negedge clk_100);
        reset_n = 1'b0;
        calib_done = 1'b0;
        cmd_stall = rows[r].cmd_stall;
        wdata_stall = rows[r].wdata_stall;
        fault_en = rows[r].fault_en;
        fault_idx = rows[r].fault_idx;
        rx_bytes.delete();
        repeat (5) @(negedge clk_100);
        reset_n = 1'b1;
        repeat (rows[r].calib_delay) @(negedge clk_100);
        calib_done = 1'b1;
        do begin
            @(posedge clk_100);
        end while (!success_led && !error_led);
        // long enough for a stray extra frame to be received completely
        repeat (11 * UART_CLKS_PER_BIT) @(posedge clk_100);

        compare_value("uart byte count", rx_bytes.size(), 16);
        if (rx_bytes.size() >= 16) begin
            for (int i = 0; i < 8; i++) begin
                first_word[8*i +: 8] = rx_bytes[i];
                second_word[8*i +: 8] = rx_bytes[i+8];
            end
        end
        compare_value("write_cycles", first_word, exp_write_cycles);
        if (rows[r].cmd_stall == 0 && rows[r].wdata_stall == 0) begin
            compare_value("write_cycles without stalls", first_word, NUM_WORDS);
        end
        if (rows[r].fault_en) begin
            compare_value("bad_index", second_word, rows[r].fault_idx);
        end else begin
            compare_value("read_cycles", second_word, exp_read_cycles);
        end
        compare_value("success_led", success_led, !rows[r].fault_en);
        compare_value("error_led", error_led, rows[r].fault_en);
        compare_value("first command delay", first_cmd_cycle - ready_cycle, 1);
        if (early_cmd) begin
            $display("cmd_en was raised while calib_done was still low");
            error_count++;
        end
        compare_value("masked writes", masked_writes, 0);
        compare_value("misaddressed writes", model_i.bad_addr_count, 0);
        for (int n = 0; n < NUM_WORDS; n++) begin
            compare_value($sformatf("word %0d data", n), model_i.mem[n],
                DATA_BASE + DATA_W'(n));
            compare_value($sformatf("word %0d write count", n), model_i.wr_count[n], 1);
        end
        $display("row %0d: write %0d cycles, second value %0d, %s", r, first_word,
            second_word, (error_count == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        reset_n = 1'b0;
        calib_done = 1'b0;
        cmd_stall = '0;
        wdata_stall = '0;
        fault_en = 1'b0;
        fault_idx = '0;
        load_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("%0d rows, %0d checks, %0d errors", NUM_ROWS, check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
verilog/mem_test_pkg.sv
verilog/uart_tx.sv
verilog/traffic_gen.sv
verilog/read_checker.sv
verilog/result_reporter.sv
verilog/mem_test_top.sv
bench/mem_model.sv
bench/tb_mem_test.sv

//--- Makefile
SOURCES := $(wildcard verilog/*.sv) $(wildcard bench/*.sv)

obj_dir/Vtb_mem_test: compile.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_test -f compile.f

run: obj_dir/Vtb_mem_test
	./obj_dir/Vtb_mem_test | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
